// File: src/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// block and round key width
`define AES_BLOCK_W 128

// state byte width
`define AES_BYTE_W 8

// AES-256 runs fourteen rounds after the initial key addition
`define AES_NUM_ROUNDS 14

// round counter width, holds 0 to 14
`define AES_ROUND_W 4

// low byte of x^8 + x^4 + x^3 + x + 1
`define AES_GF_POLY 8'h1b

`endif

// File: src/aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

  // ==========================================================================
  // state types
  // ==========================================================================

  typedef logic [`AES_BYTE_W-1:0] aes_byte_t;

  // one column of the state, r0 sits in the top byte
  typedef struct packed {
    aes_byte_t r0;
    aes_byte_t r1;
    aes_byte_t r2;
    aes_byte_t r3;
  } aes_col_t;

  // full state, c0 in the top word as on the word/round_key buses
  typedef struct packed {
    aes_col_t c0;
    aes_col_t c1;
    aes_col_t c2;
    aes_col_t c3;
  } aes_block_t;

  // ==========================================================================
  // control encodings
  // ==========================================================================

  typedef enum logic [2:0] {
    IDLE          = 3'd0,
    INIT          = 3'd1,
    SUB_BYTES     = 3'd2,
    SHIFT_ROWS    = 3'd3,
    MIX_COLUMNS   = 3'd4,
    ADD_ROUND_KEY = 3'd5,
    FINAL_KEY     = 3'd6,
    DONE          = 3'd7
  } aes_phase_e;

  // what the state register loads, XORed with round_key
  typedef enum logic [1:0] {
    KEY_SRC_HOLD  = 2'd0,
    KEY_SRC_WORD  = 2'd1,
    KEY_SRC_MIX   = 2'd2,
    KEY_SRC_SHIFT = 2'd3
  } aes_key_src_e;

  // multiply by x in GF(2^8)
  function automatic aes_byte_t xtime(aes_byte_t b);
    return {b[`AES_BYTE_W-2:0], 1'b0} ^ ({`AES_BYTE_W{b[`AES_BYTE_W-1]}} & `AES_GF_POLY);
  endfunction

endpackage

// File: src/aes_sbox.sv
`timescale 1ns/1ps

module aes_sbox import aes_pkg::*; (
  input  aes_byte_t in_byte,
  output aes_byte_t out_byte
);

  // forward table, entry 0 in the leftmost byte of the first line
  localparam aes_byte_t [0:255] SBOX = {
    128'h637c777b_f26b6fc5_3001672b_fed7ab76,
    128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
    128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
    128'h04c723c3_1896059a_071280e2_eb27b275,
    128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
    128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
    128'hd0efaafb_434d3385_45f9027f_503c9fa8,
    128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
    128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
    128'h60814fdc_222a9088_46eeb814_de5e0bdb,
    128'he0323a0a_4906245c_c2d3ac62_9195e479,
    128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
    128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
    128'h703eb566_4803f60e_613557b9_86c11d9e,
    128'he1f89811_69d98e94_9b1e87e9_ce5528df,
    128'h8ca1890d_bfe64268_41992d0f_b054bb16
  };

  assign out_byte = SBOX[in_byte];

endmodule

// File: src/aes_sub_shift.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_sub_shift import aes_pkg::*; (
  input  logic       clk,
  input  aes_block_t state_q,
  output aes_block_t shift_q
);

  localparam int NUM_BYTES = `AES_BLOCK_W / `AES_BYTE_W;

  logic [`AES_BLOCK_W-1:0] state_flat;
  logic [`AES_BLOCK_W-1:0] sub_flat;
  aes_block_t              sub_blk;
  aes_block_t              shift_d;

  assign state_flat = state_q;

  // ==========================================================================
  // sub bytes
  // ==========================================================================

  for (genvar i = 0; i < NUM_BYTES; i++) begin : g_sbox
    aes_sbox u_sbox (
      .in_byte  (state_flat[i*`AES_BYTE_W +: `AES_BYTE_W]),
      .out_byte (sub_flat[i*`AES_BYTE_W +: `AES_BYTE_W])
    );
  end

  assign sub_blk = sub_flat;

  // ==========================================================================
  // shift rows, row r of column c comes from column (c+r) mod 4
  // ==========================================================================

  assign shift_d.c0 = '{r0: sub_blk.c0.r0, r1: sub_blk.c1.r1, r2: sub_blk.c2.r2, r3: sub_blk.c3.r3};
  assign shift_d.c1 = '{r0: sub_blk.c1.r0, r1: sub_blk.c2.r1, r2: sub_blk.c3.r2, r3: sub_blk.c0.r3};
  assign shift_d.c2 = '{r0: sub_blk.c2.r0, r1: sub_blk.c3.r1, r2: sub_blk.c0.r2, r3: sub_blk.c1.r3};
  assign shift_d.c3 = '{r0: sub_blk.c3.r0, r1: sub_blk.c0.r1, r2: sub_blk.c1.r2, r3: sub_blk.c2.r3};

  // free running, the phase sequence decides when the value is used
  always_ff @(posedge clk) begin
    shift_q <= shift_d;
  end

endmodule

// File: src/aes_mix_columns.sv
`timescale 1ns/1ps

module aes_mix_columns import aes_pkg::*; (
  input  logic       clk,
  input  aes_block_t shift_q,
  output aes_block_t mix_q
);

  aes_block_t mix_d;

  // 2 3 1 1 circulant on one column
  function automatic aes_col_t mix_col(aes_col_t c);
    aes_col_t  m;
    aes_byte_t x0;
    aes_byte_t x1;
    aes_byte_t x2;
    aes_byte_t x3;
    x0 = xtime(c.r0);
    x1 = xtime(c.r1);
    x2 = xtime(c.r2);
    x3 = xtime(c.r3);
    // 3*a is xtime(a) ^ a
    m.r0 = x0 ^ (x1 ^ c.r1) ^ c.r2 ^ c.r3;
    m.r1 = c.r0 ^ x1 ^ (x2 ^ c.r2) ^ c.r3;
    m.r2 = c.r0 ^ c.r1 ^ x2 ^ (x3 ^ c.r3);
    m.r3 = (x0 ^ c.r0) ^ c.r1 ^ c.r2 ^ x3;
    return m;
  endfunction

  // ==========================================================================
  // four independent columns
  // ==========================================================================

  always_comb begin
    mix_d.c0 = mix_col(shift_q.c0);
    mix_d.c1 = mix_col(shift_q.c1);
    mix_d.c2 = mix_col(shift_q.c2);
    mix_d.c3 = mix_col(shift_q.c3);
  end

  always_ff @(posedge clk) begin
    mix_q <= mix_d;
  end

endmodule

// File: src/aes_key_add.sv
`timescale 1ns/1ps

module aes_key_add import aes_pkg::*; (
  input  logic         clk,
  input  aes_key_src_e key_src,
  input  aes_block_t   word,
  input  aes_block_t   round_key,
  input  aes_block_t   mix_q,
  input  aes_block_t   shift_q,
  output aes_block_t   state_q
);

  aes_block_t src_blk;

  // source picked by the controller
  always_comb begin
    case (key_src)
      KEY_SRC_WORD:  src_blk = word;
      KEY_SRC_MIX:   src_blk = mix_q;
      KEY_SRC_SHIFT: src_blk = shift_q;
      default:       src_blk = state_q;
    endcase
  end

  // ==========================================================================
  // state register between rounds
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (key_src != KEY_SRC_HOLD) begin
      state_q <= src_blk ^ round_key;
    end
  end

endmodule

// File: src/aes_round_ctrl.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_round_ctrl import aes_pkg::*; (
  input  logic                    clk,
  input  logic                    srst_n,
  input  logic                    encrypt_en,
  output aes_key_src_e            key_src,
  output logic [`AES_ROUND_W-1:0] round,
  output logic                    done
);

  localparam logic [`AES_ROUND_W-1:0] LAST_ROUND = `AES_ROUND_W'(`AES_NUM_ROUNDS);

  aes_phase_e              phase_q;
  aes_phase_e              phase_d;
  logic [`AES_ROUND_W-1:0] round_q;
  logic                    done_q;
  logic                    start;

  // encrypt_en only counts in idle
  assign start = (phase_q == IDLE) && encrypt_en;

  // ==========================================================================
  // phase sequence
  // ==========================================================================

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      IDLE: begin
        if (encrypt_en) begin
          phase_d = INIT;
        end
      end
      INIT:          phase_d = SUB_BYTES;
      SUB_BYTES:     phase_d = SHIFT_ROWS;
      // round already stepped at the end of sub bytes
      SHIFT_ROWS: begin
        if (round_q == LAST_ROUND) begin
          phase_d = FINAL_KEY;
        end else begin
          phase_d = MIX_COLUMNS;
        end
      end
      MIX_COLUMNS:   phase_d = ADD_ROUND_KEY;
      ADD_ROUND_KEY: phase_d = SUB_BYTES;
      FINAL_KEY:     phase_d = DONE;
      DONE:          phase_d = IDLE;
      default:       phase_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      phase_q <= IDLE;
      round_q <= '0;
      done_q  <= 1'b0;
    end else begin
      phase_q <= phase_d;
      done_q  <= (phase_q == FINAL_KEY);
      if (start) begin
        round_q <= '0;
      end else if (phase_q == SUB_BYTES) begin
        round_q <= round_q + 1'b1;
      end
    end
  end

  // ==========================================================================
  // state register source
  // ==========================================================================

  always_comb begin
    case (phase_q)
      INIT:          key_src = KEY_SRC_WORD;
      ADD_ROUND_KEY: key_src = KEY_SRC_MIX;
      // last round skips mix columns
      FINAL_KEY:     key_src = KEY_SRC_SHIFT;
      default:       key_src = KEY_SRC_HOLD;
    endcase
  end

  assign round = round_q;
  assign done  = done_q;

endmodule

// File: src/aes_encrypt_top.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_encrypt_top import aes_pkg::*; (
  input  logic                    clk,
  input  logic                    srst_n,
  input  logic                    encrypt_en,
  input  aes_block_t              word,
  input  aes_block_t              round_key,
  output aes_block_t              encrypted_word,
  output logic [`AES_ROUND_W-1:0] round,
  output logic                    done
);

  aes_key_src_e key_src;
  aes_block_t   state_q;
  aes_block_t   shift_q;
  aes_block_t   mix_q;

  // ==========================================================================
  // control
  // ==========================================================================

  aes_round_ctrl u_round_ctrl (
    .clk        (clk),
    .srst_n     (srst_n),
    .encrypt_en (encrypt_en),
    .key_src    (key_src),
    .round      (round),
    .done       (done)
  );

  // ==========================================================================
  // datapath, state -> sub/shift -> mix -> back to state
  // ==========================================================================

  aes_key_add u_key_add (
    .clk       (clk),
    .key_src   (key_src),
    .word      (word),
    .round_key (round_key),
    .mix_q     (mix_q),
    .shift_q   (shift_q),
    .state_q   (state_q)
  );

  aes_sub_shift u_sub_shift (
    .clk     (clk),
    .state_q (state_q),
    .shift_q (shift_q)
  );

  aes_mix_columns u_mix_columns (
    .clk     (clk),
    .shift_q (shift_q),
    .mix_q   (mix_q)
  );

  // holds the ciphertext from done until the next start
  assign encrypted_word = state_q;

endmodule

// File: verif/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// ============================================================================
// reference model, built from the GF(2^8) rules
// ============================================================================

logic [7:0]   sbox_ref [0:255];
logic [127:0] round_keys [0:`AES_NUM_ROUNDS];

function automatic logic [7:0] gf_double(logic [7:0] b);
  return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
  logic [7:0] acc;
  logic [7:0] p;
  acc = 8'h00;
  p = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      acc = acc ^ p;
    end
    p = gf_double(p);
  end
  return acc;
endfunction

// a^254 is the inverse, zero maps to zero
function automatic logic [7:0] gf_inverse(logic [7:0] a);
  logic [7:0] r;
  r = 8'h01;
  for (int i = 0; i < 254; i++) begin
    r = gf_mul(r, a);
  end
  return r;
endfunction

function automatic logic [7:0] rotl8(logic [7:0] b, int n);
  return (b << n) | (b >> (8 - n));
endfunction

// inverse then affine transform
task automatic build_sbox_table();
  logic [7:0] inv;
  for (int x = 0; x < 256; x++) begin
    inv = gf_inverse(8'(x));
    sbox_ref[x] = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ 8'h63;
  end
endtask

function automatic logic [31:0] sub_word(logic [31:0] w);
  return {sbox_ref[w[31:24]], sbox_ref[w[23:16]], sbox_ref[w[15:8]], sbox_ref[w[7:0]]};
endfunction

// AES-256 schedule, 60 words give 15 round keys
task automatic expand_key(input logic [255:0] key);
  logic [31:0] w [0:59];
  logic [31:0] temp;
  logic [7:0]  rcon;
  rcon = 8'h01;
  for (int i = 0; i < 60; i++) begin
    if (i < 8) begin
      w[i] = key[255-32*i -: 32];
    end else begin
      temp = w[i-1];
      if (i % 8 == 0) begin
        temp = sub_word({temp[23:0], temp[31:24]}) ^ {rcon, 24'h000000};
        rcon = gf_double(rcon);
      end else if (i % 8 == 4) begin
        temp = sub_word(temp);
      end
      w[i] = w[i-8] ^ temp;
    end
  end
  for (int r = 0; r <= `AES_NUM_ROUNDS; r++) begin
    round_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  end
endtask

// byte i is column i/4, row i%4, counted from the top
function automatic logic [127:0] encrypt_block(logic [127:0] pt);
  logic [127:0] blk;
  logic [7:0]   sb [0:15];
  logic [7:0]   sr [0:15];
  blk = pt ^ round_keys[0];
  for (int r = 1; r <= `AES_NUM_ROUNDS; r++) begin
    for (int i = 0; i < 16; i++) begin
      sb[i] = sbox_ref[blk[127-8*i -: 8]];
    end
    // row j of column c comes from column c+j
    for (int i = 0; i < 16; i++) begin
      sr[i] = sb[4*((i/4 + i%4) % 4) + i%4];
    end
    for (int i = 0; i < 16; i++) begin
      if (r < `AES_NUM_ROUNDS) begin
        blk[127-8*i -: 8] = gf_mul(8'h02, sr[i]) ^ gf_mul(8'h03, sr[4*(i/4) + (i+1)%4])
                          ^ sr[4*(i/4) + (i+2)%4] ^ sr[4*(i/4) + (i+3)%4];
      end else begin
        blk[127-8*i -: 8] = sr[i];
      end
    end
    blk = blk ^ round_keys[r];
  end
  return blk;
endfunction

`endif

// File: verif/aes_tb.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_tb import aes_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int NUM_RANDOM   = 20;
  // fips vector, random runs, two starts with encrypt_en held
  localparam int NUM_OPS      = NUM_RANDOM + 3;
  localparam int CYCLE_LIMIT  = NUM_OPS * 80 + RESET_CYCLES;
  // start edge to the edge that first sees done
  localparam int DONE_EDGE    = 57;
  localparam logic [`AES_ROUND_W-1:0] LAST_ROUND = `AES_NUM_ROUNDS;

  localparam logic [`AES_BLOCK_W-1:0] FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [255:0]            FIPS_KEY =
    256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
  localparam logic [`AES_BLOCK_W-1:0] FIPS_CT  = 128'h8ea2b7ca516745bfeafc49904b496089;

  logic                    clk = 1'b0;
  logic                    srst_n;
  logic                    encrypt_en;
  aes_block_t              word;
  aes_block_t              round_key = '0;
  aes_block_t              encrypted_word;
  logic [`AES_ROUND_W-1:0] round;
  logic                    done;

  logic        op_over = 1'b0;
  logic [31:0] lfsr_state = 32'hdda4_0ea5;
  int          cycle_count = 0;

  `include "aes_model.svh"

  aes_encrypt_top DUT (
    .clk            (clk),
    .srst_n         (srst_n),
    .encrypt_en     (encrypt_en),
    .word           (word),
    .round_key      (round_key),
    .encrypted_word (encrypted_word),
    .round          (round),
    .done           (done)
  );

  always #5 clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic report_failure(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, logic [255:0] got, logic [255:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERR %s got %0h expected %0h", name, got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [255:0] random_wide(int words);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < words; i++) begin
      v = {v[223:0], take_bits(32)};
    end
    return v;
  endfunction

  // returns on the edge that samples encrypt_en in idle
  task automatic start_op(input logic [`AES_BLOCK_W-1:0] pt, input logic hold);
    word       <= pt;
    encrypt_en <= 1'b1;
    @(posedge clk);
    encrypt_en <= hold;
  endtask

  task automatic follow_op(input logic [`AES_BLOCK_W-1:0] exp_ct);
    int k;
    int exp_round;
    k = 0;
    do begin
      @(posedge clk);
      k++;
      // round steps at edges E0+2, E0+6 and so on up to E0+54
      exp_round = (k + 1) / 4;
      if (exp_round > `AES_NUM_ROUNDS) begin
        exp_round = `AES_NUM_ROUNDS;
      end
      check_value("round", round, exp_round);
    end while (!done);
    check_value("done edge", k, DONE_EDGE);
    check_value("round", round, LAST_ROUND);
    check_value("encrypted_word", encrypted_word, exp_ct);
  endtask

  task automatic idle_gap(input int cycles, input logic [`AES_BLOCK_W-1:0] exp_ct);
    repeat (cycles) begin
      @(posedge clk);
      check_value("done", done, 0);
      check_value("encrypted_word", encrypted_word, exp_ct);
    end
  endtask

  // ==========================================================================
  // key feeder and run limit
  // ==========================================================================

  // round shows 14 until the next INIT, so key 0 goes out once done is seen
  always @(posedge clk) begin
    if (done) begin
      op_over <= 1'b1;
    end else if (round != LAST_ROUND) begin
      op_over <= 1'b0;
    end
    if (round == LAST_ROUND && (done || op_over)) begin
      round_key <= round_keys[0];
    end else begin
      round_key <= round_keys[round];
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      report_failure($sformatf("timeout, run still going after %0d cycles", cycle_count));
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin
    logic [255:0]            wide;
    logic [`AES_BLOCK_W-1:0] pt;
    logic [`AES_BLOCK_W-1:0] ct;
    int                      gap;
    srst_n     = 1'b0;
    encrypt_en = 1'b0;
    word       = '0;
    build_sbox_table();
    expand_key(FIPS_KEY);
    // FIPS-197 known answer checks the model itself
    check_value("model ciphertext", encrypt_block(FIPS_PT), FIPS_CT);
    repeat (RESET_CYCLES) @(posedge clk);
    srst_n <= 1'b1;

    repeat (16) begin
      @(posedge clk);
      check_value("done", done, 0);
      check_value("round", round, 0);
    end

    start_op(FIPS_PT, 1'b0);
    follow_op(FIPS_CT);
    idle_gap(2, FIPS_CT);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      wide = random_wide(4);
      pt   = wide[`AES_BLOCK_W-1:0];
      expand_key(random_wide(8));
      ct   = encrypt_block(pt);
      start_op(pt, 1'b0);
      follow_op(ct);
      gap  = 1 + int'(take_bits(3));
      idle_gap(gap, ct);
    end

    // with encrypt_en held high the second start waits for idle
    wide = random_wide(4);
    pt   = wide[`AES_BLOCK_W-1:0];
    expand_key(random_wide(8));
    ct   = encrypt_block(pt);
    start_op(pt, 1'b1);
    follow_op(ct);
    @(posedge clk);
    check_value("done", done, 0);
    check_value("round", round, LAST_ROUND);
    check_value("encrypted_word", encrypted_word, ct);
    encrypt_en <= 1'b0;
    follow_op(ct);
    idle_gap(3, ct);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: files.f
+incdir+src
+incdir+verif
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_sub_shift.sv
src/aes_mix_columns.sv
src/aes_key_add.sv
src/aes_round_ctrl.sv
src/aes_encrypt_top.sv
verif/aes_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= aes_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(wildcard src/*.sv src/*.svh verif/*.sv verif/*.svh)
PASS_MSG := *** PASSED ***

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

check:
	@test -f $(LOG) || (echo "no log, run the simulation first"; exit 1)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
